// ==== lsu.f ====
lsu_pkg.sv
lsu_fifo.sv
load_align.sv
load_unit.sv
store_unit.sv
lsu_top.sv
tb_lsu_top.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - lsu_pkg.sv
  - lsu_fifo.sv
  - load_align.sv
  - load_unit.sv
  - store_unit.sv
  - lsu_top.sv
  - target: simulation
    files:
      - tb_lsu_top.sv

// ==== tb_lsu_top.sv ====
// load/store unit testbench
`timescale 1ns/10ps
`default_nettype none

module tb_lsu_top;

    import lsu_pkg::*;

    // about 60 requests, each well under 50 cycles even with a slow R channel
    localparam int MAX_CYCLES = 4000;

    logic                   clk;
    logic                   rst_n;
    logic                   req_mem_i;
    logic                   load_i;
    logic                   store_i;
    load_op_e               load_op_i;
    logic [XLEN-1:0]        addr_i;
    logic [XLEN-1:0]        wdata_i;
    logic [STRB_W-1:0]      wstrb_i;
    logic [REG_ADDR_W-1:0]  rd_addr_i;
    logic [COMMIT_ID_W-1:0] commit_id_i;
    logic                   int_assert_i;
    logic                   mem_stall_o;
    logic                   mem_busy_o;
    logic                   reg_we_o;
    logic [REG_ADDR_W-1:0]  reg_waddr_o;
    logic [XLEN-1:0]        reg_wdata_o;
    logic [COMMIT_ID_W-1:0] commit_id_o;
    logic [XLEN-1:0]        m_axi_awaddr_o;
    logic [PROT_W-1:0]      m_axi_awprot_o;
    logic                   m_axi_awvalid_o;
    logic                   m_axi_awready_i;
    logic [XLEN-1:0]        m_axi_wdata_o;
    logic [STRB_W-1:0]      m_axi_wstrb_o;
    logic                   m_axi_wvalid_o;
    logic                   m_axi_wready_i;
    axi_resp_e              m_axi_bresp_i;
    logic                   m_axi_bvalid_i;
    logic                   m_axi_bready_o;
    logic [XLEN-1:0]        m_axi_araddr_o;
    logic [PROT_W-1:0]      m_axi_arprot_o;
    logic                   m_axi_arvalid_o;
    logic                   m_axi_arready_i;
    logic [XLEN-1:0]        m_axi_rdata_i;
    axi_resp_e              m_axi_rresp_i;
    logic                   m_axi_rvalid_i;
    logic                   m_axi_rready_o;

    // slave memory, reference copy and pending channel state
    logic [XLEN-1:0] mem [64];
    logic [XLEN-1:0] ref_mem [64];
    logic [5:0]      rd_q [$];
    logic [5:0]      wa_q [$];
    int              b_pend;
    int              stores_open;
    logic            aw_hold;
    logic            r_slow;
    integer          seed = 47;
    logic [31:0]     rnd;

    // expected writebacks in issue order
    logic [XLEN-1:0]        exp_data [64];
    logic [REG_ADDR_W-1:0]  exp_waddr [64];
    logic [COMMIT_ID_W-1:0] exp_cid [64];
    int                     exp_head;
    int                     exp_tail;
    logic [XLEN-1:0]        exp_wdata_h;
    logic [REG_ADDR_W-1:0]  exp_waddr_h;
    logic [COMMIT_ID_W-1:0] exp_cid_h;

    int errors;
    int cycles;
    int tests_run;
    int tests_failed;
    int test_err_start;

    assign exp_wdata_h = exp_data[exp_head[5:0]];
    assign exp_waddr_h = exp_waddr[exp_head[5:0]];
    assign exp_cid_h   = exp_cid[exp_head[5:0]];

    lsu_top uut (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [XLEN-1:0] extend_load(input logic [XLEN-1:0] word,
                                                    input load_op_e op,
                                                    input logic [1:0] off);
        logic [XLEN-1:0] by_byte;
        logic [XLEN-1:0] by_half;
        by_byte = word >> (8 * off);
        by_half = word >> (16 * off[1]);
        case (op)
            LOAD_B:  return XLEN'($signed(by_byte[7:0]));
            LOAD_BU: return XLEN'(by_byte[7:0]);
            LOAD_H:  return XLEN'($signed(by_half[15:0]));
            LOAD_HU: return XLEN'(by_half[15:0]);
            default: return word;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] merge_bytes(input logic [XLEN-1:0] old,
                                                    input logic [XLEN-1:0] data,
                                                    input logic [STRB_W-1:0] strb);
        logic [XLEN-1:0] res;
        res = old;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    // called at a falling edge, returns at the falling edge after acceptance
    task automatic issue(input logic is_load, input load_op_e op, input logic [XLEN-1:0] addr,
                         input logic [XLEN-1:0] data, input logic [STRB_W-1:0] strb,
                         input logic [REG_ADDR_W-1:0] rd, input logic [COMMIT_ID_W-1:0] cid);
        logic taken;
        req_mem_i   = 1'b1;
        load_i      = is_load;
        store_i     = !is_load;
        load_op_i   = op;
        addr_i      = addr;
        wdata_i     = data;
        wstrb_i     = strb;
        rd_addr_i   = rd;
        commit_id_i = cid;
        taken       = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = !mem_stall_o;
        end
        if (is_load) begin
            exp_data[exp_tail[5:0]]  = extend_load(ref_mem[addr[7:2]], op, addr[1:0]);
            exp_waddr[exp_tail[5:0]] = rd;
            exp_cid[exp_tail[5:0]]   = cid;
            exp_tail++;
        end else begin
            ref_mem[addr[7:2]] = merge_bytes(ref_mem[addr[7:2]], data, strb);
        end
        @(negedge clk);
        req_mem_i = 1'b0;
    endtask

    task automatic load_from(input load_op_e op, input logic [XLEN-1:0] addr,
                             input logic [REG_ADDR_W-1:0] rd,
                             input logic [COMMIT_ID_W-1:0] cid);
        issue(1'b1, op, addr, '0, '0, rd, cid);
    endtask

    task automatic store_to(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data,
                            input logic [STRB_W-1:0] strb);
        issue(1'b0, LOAD_W, addr, data, strb, '0, '0);
    endtask

    task automatic masked_request(input logic is_load);
        req_mem_i    = 1'b1;
        int_assert_i = 1'b1;
        load_i       = is_load;
        store_i      = !is_load;
        addr_i       = 32'h0000_0050;
        repeat (4) @(negedge clk);
        req_mem_i    = 1'b0;
        int_assert_i = 1'b0;
    endtask

    task automatic drain();
        while (exp_head != exp_tail || mem_busy_o) begin
            @(negedge clk);
        end
    endtask

    task automatic close_test(input string name);
        drain();
        tests_run++;
        if (errors != test_err_start) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", tests_run, name, (errors == test_err_start) ? "ok" : "failed");
        test_err_start = errors;
    endtask

    // AXI4-Lite slave, channel bookkeeping on the rising edge
    always @(posedge clk) begin : slave_update
        logic [5:0] widx;
        if (rst_n) begin
            if (m_axi_arvalid_o && m_axi_arready_i) begin
                rd_q.push_back(m_axi_araddr_o[7:2]);
            end
            if (m_axi_rvalid_i && m_axi_rready_o) begin
                void'(rd_q.pop_front());
            end
            if (m_axi_awvalid_o && m_axi_awready_i) begin
                wa_q.push_back(m_axi_awaddr_o[7:2]);
                stores_open++;
            end
            if (m_axi_wvalid_o && m_axi_wready_i) begin
                widx      = wa_q.pop_front();
                mem[widx] = merge_bytes(mem[widx], m_axi_wdata_o, m_axi_wstrb_o);
                b_pend++;
            end
            if (m_axi_bvalid_i && m_axi_bready_o) begin
                b_pend--;
                stores_open--;
            end
            if (reg_we_o && exp_head != exp_tail) begin
                exp_head++;
            end
        end
    end

    // random ready and response timing, driven on the falling edge
    always @(negedge clk) begin : slave_drive
        if (!rst_n) begin
            m_axi_arready_i = 1'b0;
            m_axi_awready_i = 1'b0;
            m_axi_wready_i  = 1'b0;
            m_axi_rvalid_i  = 1'b0;
            m_axi_bvalid_i  = 1'b0;
        end else begin
            rnd             = $random(seed);
            m_axi_arready_i = (rnd[1:0] != 2'b00);
            m_axi_awready_i = !aw_hold && (rnd[3:2] != 2'b00);
            m_axi_wready_i  = (rnd[5:4] != 2'b00);
            m_axi_rvalid_i  = (rd_q.size() != 0) && (r_slow ? (rnd[9:7] == 3'b000) : rnd[6]);
            m_axi_rdata_i   = (rd_q.size() != 0) ? mem[rd_q[0]] : '0;
            m_axi_bvalid_i  = (b_pend != 0) && rnd[10];
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run not finished after %0d cycles", MAX_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    a_reset_idle: assert property (@(posedge clk) !rst_n |-> !(m_axi_arvalid_o ||
        m_axi_awvalid_o || m_axi_wvalid_o || m_axi_rready_o || m_axi_bready_o ||
        reg_we_o || mem_busy_o || mem_stall_o))
        else begin
            errors++;
            $display("error at %0t: outputs active during reset", $time);
        end

    a_wb_expected: assert property (@(posedge clk) disable iff (!rst_n)
        reg_we_o |-> exp_head != exp_tail)
        else begin
            errors++;
            $display("error at %0t: writeback with no load outstanding", $time);
        end

    a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
        reg_we_o |-> reg_wdata_o == exp_wdata_h)
        else begin
            errors++;
            $display("mismatch at %0t: reg_wdata_o expected %h actual %h", $time,
                     $sampled(exp_wdata_h), $sampled(reg_wdata_o));
        end

    a_wb_waddr: assert property (@(posedge clk) disable iff (!rst_n)
        reg_we_o |-> reg_waddr_o == exp_waddr_h)
        else begin
            errors++;
            $display("mismatch at %0t: reg_waddr_o expected %0d actual %0d", $time,
                     $sampled(exp_waddr_h), $sampled(reg_waddr_o));
        end

    a_wb_cid: assert property (@(posedge clk) disable iff (!rst_n)
        reg_we_o |-> commit_id_o == exp_cid_h)
        else begin
            errors++;
            $display("mismatch at %0t: commit_id_o expected %0d actual %0d", $time,
                     $sampled(exp_cid_h), $sampled(commit_id_o));
        end

    // plain data accesses, unprivileged and secure
    a_arprot: assert property (@(posedge clk) disable iff (!rst_n)
        m_axi_arvalid_o |-> m_axi_arprot_o == 3'b000)
        else begin
            errors++;
            $display("mismatch at %0t: m_axi_arprot_o expected %b actual %b", $time,
                     3'b000, $sampled(m_axi_arprot_o));
        end

    a_awprot: assert property (@(posedge clk) disable iff (!rst_n)
        m_axi_awvalid_o |-> m_axi_awprot_o == 3'b000)
        else begin
            errors++;
            $display("mismatch at %0t: m_axi_awprot_o expected %b actual %b", $time,
                     3'b000, $sampled(m_axi_awprot_o));
        end

    a_masked: assert property (@(posedge clk) disable iff (!rst_n)
        req_mem_i && int_assert_i |-> !m_axi_arvalid_o && !m_axi_awvalid_o && !mem_stall_o)
        else begin
            errors++;
            $display("error at %0t: masked request issued or stalled", $time);
        end

    a_stall_aw: assert property (@(posedge clk) disable iff (!rst_n)
        req_mem_i && store_i && !int_assert_i && !m_axi_awready_i |-> mem_stall_o)
        else begin
            errors++;
            $display("error at %0t: no stall while AWREADY is low", $time);
        end

    a_stall_full: assert property (@(posedge clk) disable iff (!rst_n)
        req_mem_i && load_i && !int_assert_i && (exp_tail - exp_head == LOAD_DEPTH)
        |-> mem_stall_o)
        else begin
            errors++;
            $display("error at %0t: no stall with %0d loads outstanding", $time, LOAD_DEPTH);
        end

    a_busy: assert property (@(posedge clk) disable iff (!rst_n)
        mem_busy_o == (stores_open != 0))
        else begin
            errors++;
            $display("mismatch at %0t: mem_busy_o expected %b actual %b", $time,
                     $sampled(stores_open != 0), $sampled(mem_busy_o));
        end

    // the core moves on once the stall is low, so the request must go out then
    a_taken_on_release: assert property (@(posedge clk) disable iff (!rst_n)
        req_mem_i && !int_assert_i && !mem_stall_o
        |-> (load_i ? (m_axi_arvalid_o && m_axi_arready_i)
                    : (m_axi_awvalid_o && m_axi_awready_i)))
        else begin
            errors++;
            $display("error at %0t: stall low without an address handshake", $time);
        end

    initial begin : main
        load_op_e ops [4];
        ops            = '{LOAD_B, LOAD_BU, LOAD_H, LOAD_HU};
        rst_n          = 1'b0;
        req_mem_i      = 1'b0;
        load_i         = 1'b0;
        store_i        = 1'b0;
        load_op_i      = LOAD_W;
        addr_i         = '0;
        wdata_i        = '0;
        wstrb_i        = '0;
        rd_addr_i      = '0;
        commit_id_i    = '0;
        int_assert_i   = 1'b0;
        m_axi_arready_i = 1'b0;
        m_axi_awready_i = 1'b0;
        m_axi_wready_i = 1'b0;
        m_axi_rvalid_i = 1'b0;
        m_axi_rdata_i  = '0;
        m_axi_rresp_i  = RESP_OKAY;
        m_axi_bvalid_i = 1'b0;
        m_axi_bresp_i  = RESP_OKAY;
        aw_hold        = 1'b0;
        r_slow         = 1'b0;
        b_pend         = 0;
        stores_open    = 0;
        exp_head       = 0;
        exp_tail       = 0;
        errors         = 0;
        cycles         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        test_err_start = 0;
        for (int i = 0; i < 64; i++) begin
            mem[i]     = 32'h9e37_79b9 * (i + 1);
            ref_mem[i] = mem[i];
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        for (int k = 0; k < 4; k++) begin
            store_to(32'h1000 + 32'(k * 36), $random(seed), 4'hf);
        end
        drain();
        for (int k = 0; k < 4; k++) begin
            load_from(LOAD_W, 32'h1000 + 32'(k * 36), 5'(k + 1), 3'(k));
        end
        close_test("word stores then loads");

        store_to(32'h20, 32'h80ff_7f81, 4'hf);
        store_to(32'h24, 32'h7f80_ff01, 4'hf);
        drain();
        for (int w = 0; w < 2; w++) begin
            for (int off = 0; off < 4; off++) begin
                for (int o = 0; o < 4; o++) begin
                    load_from(ops[o], 32'h20 + 32'(4 * w + off), 5'(8 * w + 4 * o + off), 3'(o));
                end
            end
        end
        close_test("byte and halfword extension");

        store_to(32'h30, 32'h1122_3344, 4'hf);
        drain();
        store_to(32'h30, 32'haabb_ccdd, 4'b0101);
        store_to(32'h34, 32'hc3c3_c3c3, 4'b1000);
        drain();
        load_from(LOAD_W, 32'h30, 5'd20, 3'd5);
        load_from(LOAD_W, 32'h34, 5'd21, 3'd6);
        close_test("partial strobes");

        r_slow = 1'b1;
        for (int k = 0; k < 6; k++) begin
            load_from(LOAD_W, 32'h1000 + 32'(k * 36), 5'(10 + k), 3'(k));
        end
        drain();
        r_slow = 1'b0;
        close_test("loads under slow R channel");

        masked_request(1'b1);
        masked_request(1'b0);
        close_test("interrupt masking");

        // hold AWREADY low from the next falling edge on
        aw_hold = 1'b1;
        @(negedge clk);
        fork
            store_to(32'h44, 32'h5a5a_0ff0, 4'hf);
            begin
                repeat (6) @(posedge clk);
                aw_hold = 1'b0;
            end
        join
        store_to(32'h48, 32'h0123_4567, 4'hf);
        drain();
        load_from(LOAD_W, 32'h44, 5'd30, 3'd1);
        load_from(LOAD_W, 32'h48, 5'd31, 3'd2);
        close_test("store back-pressure");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== lsu_top.sv ====
// load/store unit top level
`timescale 1ns/10ps
`default_nettype none

module lsu_top (
    input  wire                                clk,
    input  wire                                rst_n,

    // core request
    input  wire                                req_mem_i,
    input  wire                                load_i,
    input  wire                                store_i,
    input  wire lsu_pkg::load_op_e             load_op_i,
    input  wire [lsu_pkg::XLEN-1:0]            addr_i,
    input  wire [lsu_pkg::XLEN-1:0]            wdata_i,
    input  wire [lsu_pkg::STRB_W-1:0]          wstrb_i,
    input  wire [lsu_pkg::REG_ADDR_W-1:0]      rd_addr_i,
    input  wire [lsu_pkg::COMMIT_ID_W-1:0]     commit_id_i,
    input  wire                                int_assert_i,
    output logic                               mem_stall_o,
    output logic                               mem_busy_o,

    // writeback
    output logic                               reg_we_o,
    output logic [lsu_pkg::REG_ADDR_W-1:0]     reg_waddr_o,
    output logic [lsu_pkg::XLEN-1:0]           reg_wdata_o,
    output logic [lsu_pkg::COMMIT_ID_W-1:0]    commit_id_o,

    // AXI4-Lite master
    output logic [lsu_pkg::XLEN-1:0]           m_axi_awaddr_o,
    output logic [lsu_pkg::PROT_W-1:0]         m_axi_awprot_o,
    output logic                               m_axi_awvalid_o,
    input  wire                                m_axi_awready_i,
    output logic [lsu_pkg::XLEN-1:0]           m_axi_wdata_o,
    output logic [lsu_pkg::STRB_W-1:0]         m_axi_wstrb_o,
    output logic                               m_axi_wvalid_o,
    input  wire                                m_axi_wready_i,
    input  wire lsu_pkg::axi_resp_e            m_axi_bresp_i,
    input  wire                                m_axi_bvalid_i,
    output logic                               m_axi_bready_o,
    output logic [lsu_pkg::XLEN-1:0]           m_axi_araddr_o,
    output logic [lsu_pkg::PROT_W-1:0]         m_axi_arprot_o,
    output logic                               m_axi_arvalid_o,
    input  wire                                m_axi_arready_i,
    input  wire [lsu_pkg::XLEN-1:0]            m_axi_rdata_i,
    input  wire lsu_pkg::axi_resp_e            m_axi_rresp_i,
    input  wire                                m_axi_rvalid_i,
    output logic                               m_axi_rready_o
);

    logic mem_req;
    logic load_req;
    logic store_req;
    logic load_accept;
    logic store_accept;

    // an interrupt drops the request before anything is issued
    assign mem_req   = req_mem_i && !int_assert_i;
    assign load_req  = mem_req && load_i;
    assign store_req = mem_req && store_i;

    // core holds the request until its address handshake
    assign mem_stall_o = (load_req && !load_accept) || (store_req && !store_accept);

    load_unit u_load (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_req_i    (load_req),
        .load_op_i     (load_op_i),
        .addr_i        (addr_i),
        .rd_addr_i     (rd_addr_i),
        .commit_id_i   (commit_id_i),
        .load_accept_o (load_accept),
        .m_araddr_o    (m_axi_araddr_o),
        .m_arprot_o    (m_axi_arprot_o),
        .m_arvalid_o   (m_axi_arvalid_o),
        .m_arready_i   (m_axi_arready_i),
        .m_rdata_i     (m_axi_rdata_i),
        .m_rresp_i     (m_axi_rresp_i),
        .m_rvalid_i    (m_axi_rvalid_i),
        .m_rready_o    (m_axi_rready_o),
        .reg_we_o      (reg_we_o),
        .reg_waddr_o   (reg_waddr_o),
        .reg_wdata_o   (reg_wdata_o),
        .commit_id_o   (commit_id_o)
    );

    store_unit u_store (
        .clk            (clk),
        .rst_n          (rst_n),
        .store_req_i    (store_req),
        .addr_i         (addr_i),
        .wdata_i        (wdata_i),
        .wstrb_i        (wstrb_i),
        .store_accept_o (store_accept),
        .busy_o         (mem_busy_o),
        .m_awaddr_o     (m_axi_awaddr_o),
        .m_awprot_o     (m_axi_awprot_o),
        .m_awvalid_o    (m_axi_awvalid_o),
        .m_awready_i    (m_axi_awready_i),
        .m_wdata_o      (m_axi_wdata_o),
        .m_wstrb_o      (m_axi_wstrb_o),
        .m_wvalid_o     (m_axi_wvalid_o),
        .m_wready_i     (m_axi_wready_i),
        .m_bresp_i      (m_axi_bresp_i),
        .m_bvalid_i     (m_axi_bvalid_i),
        .m_bready_o     (m_axi_bready_o)
    );

    a_one_kind: assert property (@(posedge clk) disable iff (!rst_n)
        req_mem_i |-> !(load_i && store_i))
        else $error("lsu_top: load and store requested together");

endmodule

`default_nettype wire

// ==== store_unit.sv ====
// store path, AW/W/B channels
`timescale 1ns/10ps
`default_nettype none

module store_unit (
    input  wire                              clk,
    input  wire                              rst_n,

    // request from the core
    input  wire                              store_req_i,
    input  wire [lsu_pkg::XLEN-1:0]          addr_i,
    input  wire [lsu_pkg::XLEN-1:0]          wdata_i,
    input  wire [lsu_pkg::STRB_W-1:0]        wstrb_i,
    output logic                             store_accept_o,
    output logic                             busy_o,

    // write address channel
    output logic [lsu_pkg::XLEN-1:0]         m_awaddr_o,
    output logic [lsu_pkg::PROT_W-1:0]       m_awprot_o,
    output logic                             m_awvalid_o,
    input  wire                              m_awready_i,

    // write data channel
    output logic [lsu_pkg::XLEN-1:0]         m_wdata_o,
    output logic [lsu_pkg::STRB_W-1:0]       m_wstrb_o,
    output logic                             m_wvalid_o,
    input  wire                              m_wready_i,

    // write response channel
    input  wire lsu_pkg::axi_resp_e          m_bresp_i,
    input  wire                              m_bvalid_i,
    output logic                             m_bready_o
);

    import lsu_pkg::*;

    logic [XLEN+STRB_W-1:0] sq_push_data;
    logic [XLEN+STRB_W-1:0] sq_head;
    logic                   sq_empty;
    logic                   sq_full;
    logic [OUT_CNT_W-1:0]   out_cnt_q;
    logic                   cnt_full;
    logic                   aw_hs;
    logic                   w_hs;
    logic                   b_hs;

    // cap writes in flight so the counter and queue stay in step
    assign cnt_full = (out_cnt_q == OUT_CNT_W'(STORE_DEPTH));

    assign m_awaddr_o  = addr_i;
    assign m_awprot_o  = AXI_PROT_DATA;
    assign m_awvalid_o = store_req_i && !sq_full && !cnt_full;
    assign aw_hs       = m_awvalid_o && m_awready_i;

    assign store_accept_o = aw_hs;

    // data captured on AW, drained onto W from the next cycle
    assign sq_push_data = {wdata_i, wstrb_i};

    lsu_fifo #(
        .WIDTH (XLEN + STRB_W),
        .DEPTH (STORE_DEPTH)
    ) u_store_q (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (aw_hs),
        .push_data_i (sq_push_data),
        .pop_i       (w_hs),
        .head_o      (sq_head),
        .empty_o     (sq_empty),
        .full_o      (sq_full)
    );

    assign m_wvalid_o = !sq_empty;
    assign {m_wdata_o, m_wstrb_o} = sq_head;
    assign w_hs = m_wvalid_o && m_wready_i;

    // write responses are only counted
    assign m_bready_o = (out_cnt_q != '0);
    assign b_hs       = m_bvalid_i && m_bready_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_cnt_q <= '0;
        end else if (aw_hs && !b_hs) begin
            out_cnt_q <= out_cnt_q + 1'b1;
        end else if (b_hs && !aw_hs) begin
            out_cnt_q <= out_cnt_q - 1'b1;
        end
    end

    assign busy_o = !sq_empty || (out_cnt_q != '0);

    // slave must not answer a write that was never issued
    a_bvalid_with_write: assert property (@(posedge clk) disable iff (!rst_n)
        m_bvalid_i |-> out_cnt_q != '0)
        else $error("store_unit: BVALID with no write outstanding (resp %s)",
                    m_bresp_i.name());

endmodule

`default_nettype wire

// ==== load_unit.sv ====
// load path, AR/R channels and writeback
`timescale 1ns/10ps
`default_nettype none

module load_unit (
    input  wire                                clk,
    input  wire                                rst_n,

    // request from the core
    input  wire                                load_req_i,
    input  wire lsu_pkg::load_op_e             load_op_i,
    input  wire [lsu_pkg::XLEN-1:0]            addr_i,
    input  wire [lsu_pkg::REG_ADDR_W-1:0]      rd_addr_i,
    input  wire [lsu_pkg::COMMIT_ID_W-1:0]     commit_id_i,
    output logic                               load_accept_o,

    // read address channel
    output logic [lsu_pkg::XLEN-1:0]           m_araddr_o,
    output logic [lsu_pkg::PROT_W-1:0]         m_arprot_o,
    output logic                               m_arvalid_o,
    input  wire                                m_arready_i,

    // read data channel
    input  wire [lsu_pkg::XLEN-1:0]            m_rdata_i,
    input  wire lsu_pkg::axi_resp_e            m_rresp_i,
    input  wire                                m_rvalid_i,
    output logic                               m_rready_o,

    // register writeback
    output logic                               reg_we_o,
    output logic [lsu_pkg::REG_ADDR_W-1:0]     reg_waddr_o,
    output logic [lsu_pkg::XLEN-1:0]           reg_wdata_o,
    output logic [lsu_pkg::COMMIT_ID_W-1:0]    commit_id_o
);

    import lsu_pkg::*;

    load_tag_t push_tag;
    load_tag_t head_tag;
    logic      tag_empty;
    logic      tag_full;
    logic      ar_hs;
    logic      r_hs;

    // response status is not checked, data is written back as is
    assign m_araddr_o  = addr_i;
    assign m_arprot_o  = AXI_PROT_DATA;
    assign m_arvalid_o = load_req_i && !tag_full;
    assign ar_hs       = m_arvalid_o && m_arready_i;

    assign load_accept_o = ar_hs;

    assign push_tag.rd_addr   = rd_addr_i;
    assign push_tag.commit_id = commit_id_i;
    assign push_tag.op        = load_op_i;
    assign push_tag.offset    = addr_i[OFFSET_W-1:0];

    // responses are in order, so the oldest tag owns the beat
    assign m_rready_o = !tag_empty;
    assign r_hs       = m_rvalid_i && m_rready_o;

    lsu_fifo #(
        .WIDTH ($bits(load_tag_t)),
        .DEPTH (LOAD_DEPTH)
    ) u_tag_q (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (ar_hs),
        .push_data_i (push_tag),
        .pop_i       (r_hs),
        .head_o      (head_tag),
        .empty_o     (tag_empty),
        .full_o      (tag_full)
    );

    load_align u_align (
        .rdata_i   (m_rdata_i),
        .load_op_i (head_tag.op),
        .offset_i  (head_tag.offset),
        .result_o  (reg_wdata_o)
    );

    assign reg_we_o    = r_hs;
    assign reg_waddr_o = head_tag.rd_addr;
    assign commit_id_o = head_tag.commit_id;

    // slave must not return data for a read it has not taken
    a_rvalid_with_tag: assert property (@(posedge clk) disable iff (!rst_n)
        m_rvalid_i |-> !tag_empty)
        else $error("load_unit: RVALID with no load outstanding (resp %s)",
                    m_rresp_i.name());

endmodule

`default_nettype wire

// ==== load_align.sv ====
// load data alignment and extension
`timescale 1ns/10ps
`default_nettype none

module load_align (
    input  wire [lsu_pkg::XLEN-1:0]     rdata_i,
    input  wire lsu_pkg::load_op_e      load_op_i,
    input  wire [lsu_pkg::OFFSET_W-1:0] offset_i,
    output logic [lsu_pkg::XLEN-1:0]    result_o
);

    import lsu_pkg::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // byte lane picked by the full offset
    assign byte_sel = rdata_i[8*offset_i +: 8];

    // halfword by the upper offset bit only
    assign half_sel = rdata_i[16*offset_i[OFFSET_W-1] +: 16];

    always_comb begin
        case (load_op_i)
            LOAD_B: begin
                result_o = {{(XLEN - 8){byte_sel[7]}}, byte_sel};
            end
            LOAD_BU: begin
                result_o = {{(XLEN - 8){1'b0}}, byte_sel};
            end
            LOAD_H: begin
                result_o = {{(XLEN - 16){half_sel[15]}}, half_sel};
            end
            LOAD_HU: begin
                result_o = {{(XLEN - 16){1'b0}}, half_sel};
            end
            LOAD_W: begin
                result_o = rdata_i;
            end
            default: begin
                // unused encodings return the raw word
                result_o = rdata_i;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== lsu_fifo.sv ====
// synchronous queue
`timescale 1ns/10ps
`default_nettype none

module lsu_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              push_i,
    input  wire [WIDTH-1:0]  push_data_i,
    input  wire              pop_i,
    output logic [WIDTH-1:0] head_o,
    output logic             empty_o,
    output logic             full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [DEPTH-1:0] valid_q;

    // wrap at DEPTH so non power of two depths work
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            valid_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q          <= ptr_inc(wr_ptr_q);
                valid_q[wr_ptr_q] <= 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q          <= ptr_inc(rd_ptr_q);
                valid_q[rd_ptr_q] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    // pointers meet on a valid slot when full, on an empty one otherwise
    assign head_o  = mem_q[rd_ptr_q];
    assign empty_o = (wr_ptr_q == rd_ptr_q) && !valid_q[rd_ptr_q];
    assign full_o  = (wr_ptr_q == rd_ptr_q) && valid_q[wr_ptr_q];

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push_i |-> !full_o)
        else $error("lsu_fifo: push while full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop_i |-> !empty_o)
        else $error("lsu_fifo: pop while empty");

endmodule

`default_nettype wire

// ==== lsu_pkg.sv ====
// load/store unit shared types
// widths, depths and AXI4-Lite codes
`default_nettype none

package lsu_pkg;

    // datapath
    localparam int XLEN        = 32;
    localparam int STRB_W      = XLEN / 8;
    localparam int OFFSET_W    = $clog2(STRB_W);
    localparam int REG_ADDR_W  = 5;
    localparam int COMMIT_ID_W = 3;

    // queue depths
    localparam int LOAD_DEPTH  = 4;
    localparam int STORE_DEPTH = 4;
    localparam int OUT_CNT_W   = $clog2(STORE_DEPTH + 1);

    // unprivileged, secure, data access
    localparam int                PROT_W        = 3;
    localparam logic [PROT_W-1:0] AXI_PROT_DATA = 3'b000;

    // load opcodes, funct3 encoding of the base ISA
    typedef enum logic [2:0] {
        LOAD_B  = 3'b000,
        LOAD_H  = 3'b001,
        LOAD_W  = 3'b010,
        LOAD_BU = 3'b100,
        LOAD_HU = 3'b101
    } load_op_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    // per-load context kept until its read data returns
    typedef struct packed {
        logic [REG_ADDR_W-1:0]  rd_addr;
        logic [COMMIT_ID_W-1:0] commit_id;
        load_op_e               op;
        logic [OFFSET_W-1:0]    offset;
    } load_tag_t;

endpackage

`default_nettype wire
